//--- Makefile
TB  = ht_xlat_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module ht_xlat_top -f all.f

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TB) -f all.f -o $(TB)
	./obj_dir/$(TB) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- all.f
verilog/ht_pkg.sv
verilog/ht_group_if.sv
verilog/ht_probe_if.sv
verilog/ht_group_ram.sv
verilog/ht_page_fault.sv
verilog/ht_walker.sv
verilog/ht_xlat_top.sv
verification/ht_xlat_tb.sv

//--- verification/ht_patterns.txt
# W group slot vpn ppn : table write, all fields in hex
# L vpn limit found fault ppn fault_group : lookup and its expected response
W 026 3 04834 beef
W 100 0 00100 1234
W 200 0 a0000 1000
W 200 1 a0001 1001
W 200 2 a0002 1002
W 200 3 a0003 1003
W 200 4 a0004 1004
W 200 5 a0005 1005
W 200 6 a0006 1006
W 200 7 a0007 1007
W 201 0 b0000 2000
W 201 1 b0001 2001
W 201 2 b0002 2002
W 201 3 b0003 2003
W 201 4 b0004 2004
W 201 5 00200 5a5a
W 201 6 b0006 2006
W 201 7 b0007 2007
L 04834 0 1 0 beef 00000
L 00100 0 1 0 1234 00000
L 09800 0 0 1 0000 026f7
L 00055 0 0 1 0000 055ff
L 00601 0 0 1 0000 20000
L 00200 1 1 0 5a5a 00000
L 00601 1 0 1 0000 20000
L 00601 2 0 1 0000 202ff
W 026 0 09800 0a0a
L 09800 2 1 0 0a0a 00000
L 04834 3 1 0 beef 00000

//--- verification/ht_xlat_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ht_xlat_tb;
	import ht_pkg::*;

	// ==============================
	// DUT signals
	// ==============================

	logic                   clk;
	logic                   rst;
	logic [ht_bounce_w-1:0] max_bounce;
	logic                   req_valid;
	logic                   req_ready;
	logic [ht_vpn_w-1:0]    req_vpn;
	logic                   resp_valid;
	logic                   resp_ready;
	logic                   resp_found;
	logic                   resp_fault;
	logic [ht_ppn_w-1:0]    resp_ppn;
	logic [ht_fault_w-1:0]  resp_fault_group;
	logic                   wr_en;
	logic [ht_group_w-1:0]  wr_group;
	logic [2:0]             wr_slot;
	logic [ht_vpn_w-1:0]    wr_vpn;
	logic [ht_ppn_w-1:0]    wr_ppn;

	// One entry per pattern line, field 0 is the first value after the letter
	logic [7:0]       pat_kind [$];
	logic [5:0][31:0] pat_fields [$];

	int fail_count = 0;
	bit loaded     = 1'b0;

	ht_xlat_top u_ht_xlat_top (
		.clk              (clk),
		.rst              (rst),
		.max_bounce       (max_bounce),
		.req_valid        (req_valid),
		.req_ready        (req_ready),
		.req_vpn          (req_vpn),
		.resp_valid       (resp_valid),
		.resp_ready       (resp_ready),
		.resp_found       (resp_found),
		.resp_fault       (resp_fault),
		.resp_ppn         (resp_ppn),
		.resp_fault_group (resp_fault_group),
		.wr_en            (wr_en),
		.wr_group         (wr_group),
		.wr_slot          (wr_slot),
		.wr_vpn           (wr_vpn),
		.wr_ppn           (wr_ppn)
	);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// ==============================
	// Checks
	// ==============================

	task automatic end_with_failure();
		fail_count++;
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_ppn(input string name, input logic [ht_ppn_w-1:0] got,
			input logic [ht_ppn_w-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_fault_group(input string name, input logic [ht_fault_w-1:0] got,
			input logic [ht_fault_w-1:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			end_with_failure();
		end
	endtask

	// ==============================
	// Pattern file
	// ==============================

	// Lines start with W, L or # and the letter is taken with $fgetc
	task automatic load_patterns();
		int fd;
		int c;
		int n;
		logic [31:0] v0, v1, v2, v3, v4, v5;
		logic [8*128-1:0] skip_line;
		fd = $fopen("verification/ht_patterns.txt", "r");
		if (fd == 0) begin
			$display("Could not open the pattern file verification/ht_patterns.txt");
			end_with_failure();
		end
		c = $fgetc(fd);
		while (c != -1) begin
			v4 = '0;
			v5 = '0;
			if (c == "W") begin
				n = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
				if (n != 4) begin
					$display("A table write line in the pattern file is incomplete");
					end_with_failure();
				end
				pat_kind.push_back(8'(c));
				pat_fields.push_back({v5, v4, v3, v2, v1, v0});
			end else if (c == "L") begin
				n = $fscanf(fd, "%h %h %h %h %h %h", v0, v1, v2, v3, v4, v5);
				if (n != 6) begin
					$display("A lookup line in the pattern file is incomplete");
					end_with_failure();
				end
				pat_kind.push_back(8'(c));
				pat_fields.push_back({v5, v4, v3, v2, v1, v0});
			end else if (c == "#") begin
				n = $fgets(skip_line, fd);
			end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
				$display("The pattern file holds a line of unknown kind");
				end_with_failure();
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// ==============================
	// Stimulus
	// ==============================

	// Tasks start and end 10 ns after a rising edge
	task automatic apply_reset();
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#10;
		rst = 1'b0;
	endtask

	task automatic write_slot(input logic [ht_group_w-1:0] group, input logic [2:0] slot,
			input logic [ht_vpn_w-1:0] vpn, input logic [ht_ppn_w-1:0] ppn);
		wr_group = group;
		wr_slot  = slot;
		wr_vpn   = vpn;
		wr_ppn   = ppn;
		wr_en    = 1'b1;
		@(posedge clk);
		#10;
		wr_en = 1'b0;
	endtask

	task automatic run_lookup(input logic [ht_vpn_w-1:0] vpn,
			input logic [ht_bounce_w-1:0] limit, input logic exp_found,
			input logic exp_fault, input logic [ht_ppn_w-1:0] exp_ppn,
			input logic [ht_fault_w-1:0] exp_fg);
		int waited;
		int wait_max;
		int hold;
		logic                  held_found;
		logic                  held_fault;
		logic [ht_ppn_w-1:0]   held_ppn;
		logic [ht_fault_w-1:0] held_fg;
		check_flag("req_ready", req_ready, 1'b1);
		max_bounce = limit;
		req_vpn    = vpn;
		req_valid  = 1'b1;
		@(posedge clk);
		#10;
		req_valid = 1'b0;
		// Two cycles per probe and one for the fault word, with some slack
		wait_max = 2 * (int'(limit) + 1) + 4;
		waited   = 0;
		while (!resp_valid) begin
			if (waited == wait_max) begin
				$display("No response within %0d cycles for VPN 0x%h", wait_max, vpn);
				end_with_failure();
			end
			check_flag("req_ready", req_ready, 1'b0);
			@(posedge clk);
			#10;
			waited++;
		end
		check_flag("resp_found", resp_found, exp_found);
		check_flag("resp_fault", resp_fault, exp_fault);
		check_ppn("resp_ppn", resp_ppn, exp_ppn);
		check_fault_group("resp_fault_group", resp_fault_group, exp_fg);
		held_found = resp_found;
		held_fault = resp_fault;
		held_ppn   = resp_ppn;
		held_fg    = resp_fault_group;
		// Consumer stalls for a random stretch, the response must not move
		hold = int'($urandom % 4);
		repeat (hold) begin
			@(posedge clk);
			#10;
			check_flag("resp_valid", resp_valid, 1'b1);
			check_flag("req_ready", req_ready, 1'b0);
			check_flag("resp_found", resp_found, held_found);
			check_flag("resp_fault", resp_fault, held_fault);
			check_ppn("resp_ppn", resp_ppn, held_ppn);
			check_fault_group("resp_fault_group", resp_fault_group, held_fg);
		end
		resp_ready = 1'b1;
		@(posedge clk);
		#10;
		resp_ready = 1'b0;
		check_flag("resp_valid", resp_valid, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin : main
		logic [7:0]       kind;
		logic [5:0][31:0] f;
		rst        = 1'b1;
		max_bounce = '0;
		req_valid  = 1'b0;
		req_vpn    = '0;
		resp_ready = 1'b0;
		wr_en      = 1'b0;
		wr_group   = '0;
		wr_slot    = '0;
		wr_vpn     = '0;
		wr_ppn     = '0;
		void'($urandom(32'h3b72_73a3));
		load_patterns();
		loaded = 1'b1;
		apply_reset();
		// Idle after reset, nothing requested yet
		check_flag("resp_valid", resp_valid, 1'b0);
		check_flag("req_ready", req_ready, 1'b1);
		foreach (pat_kind[i]) begin
			kind = pat_kind[i];
			f    = pat_fields[i];
			if (kind == "W") begin
				write_slot(f[0][ht_group_w-1:0], f[1][2:0], f[2][ht_vpn_w-1:0],
					f[3][ht_ppn_w-1:0]);
			end else begin
				run_lookup(f[0][ht_vpn_w-1:0], f[1][ht_bounce_w-1:0], f[2][0], f[3][0],
					f[4][ht_ppn_w-1:0], f[5][ht_fault_w-1:0]);
			end
		end
		if (fail_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Budget of 400 cycles for every pattern line
	initial begin : watchdog
		int budget;
		wait (loaded);
		budget = 400 * pat_kind.size();
		repeat (budget) @(posedge clk);
		$display("Watchdog expired after %0d cycles and the run did not finish", budget);
		end_with_failure();
	end

endmodule

`default_nettype wire

//--- verilog/ht_group_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ht_group_if;
	import ht_pkg::*;

	// Read enable and the group to fetch
	logic                          rd_en;
	logic [ht_group_w-1:0]         rd_group;

	// Whole group, slot zero in the low bits, valid one cycle after rd_en
	logic [ht_slots*ht_entry_w-1:0] rd_slots;

	// The walker issues reads and consumes the returned group
	modport walker (
		output rd_en,
		output rd_group,
		input  rd_slots
	);

	// The store answers every read in exactly one cycle
	modport ram (
		input  rd_en,
		input  rd_group,
		output rd_slots
	);

endinterface

`default_nettype wire

//--- verilog/ht_group_ram.sv
`timescale 1ns/1ps
`default_nettype none

module ht_group_ram (
	input  logic                          clk,
	input  logic                          wr_en,
	input  logic [ht_pkg::ht_group_w-1:0] wr_group,
	input  logic [2:0]                    wr_slot,
	input  logic [ht_pkg::ht_entry_w-1:0] wr_entry,
	ht_group_if.ram                       grp
);
	import ht_pkg::*;

	// ==============================
	// Slot banks
	// ==============================

	// One bank per slot, so a write touches a single slot
	// while a read returns all eight side by side
	for (genvar s = 0; s < ht_slots; s++) begin : g_slot
		logic [ht_entry_w-1:0] bank [ht_groups];
		logic [ht_entry_w-1:0] rd_q;

		// Every slot starts out invalid
		initial begin
			for (int g = 0; g < ht_groups; g++) begin
				bank[g] = '0;
			end
		end

		// Write lands on the next edge when this slot is addressed
		always_ff @(posedge clk) begin
			if (wr_en && (wr_slot == 3'(s))) begin
				bank[wr_group] <= wr_entry;
			end
		end

		// Registered read, a same-cycle write is seen by the following read
		always_ff @(posedge clk) begin
			if (grp.rd_en) begin
				rd_q <= bank[grp.rd_group];
			end
		end

		// Slot s occupies its own lane of the group word
		assign grp.rd_slots[s*ht_entry_w +: ht_entry_w] = rd_q;
	end

	// ==============================
	// Checks
	// ==============================

	// A write must name a known group and a slot that exists
	a_wr_slot_range : assert property (
		@(posedge clk)
		wr_en |-> (!$isunknown({wr_group, wr_slot}) && (wr_slot < ht_slots))
	);

endmodule

`default_nettype wire

//--- verilog/ht_page_fault.sv
`timescale 1ns/1ps
`default_nettype none

module ht_page_fault (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [ht_pkg::ht_bounce_w-1:0] max_bounce,
	ht_probe_if.detect                     prb
);
	import ht_pkg::*;

	logic miss;
	logic has_empty;
	logic at_limit;

	// A miss with room left faults on the current group
	// A miss on a full group faults only once the bounce limit is reached
	assign miss      = prb.xlat && !prb.found;
	assign has_empty = |prb.empty;
	assign at_limit  = (prb.bounce == max_bounce);

	// Decision is combinational so the walker can branch in the compare cycle
	always_comb begin
		prb.page_fault = miss && (has_empty || at_limit);
	end

	// ==============================
	// Fault word
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			prb.fault_group <= ht_fault_rst;
		end else if (miss) begin
			if (has_empty) begin
				// Point software at the free slots of the group just probed
				prb.fault_group <= {prb.current_group, prb.empty};
			end else if (at_limit) begin
				// Out of bounces so the home group is reported with nothing free
				prb.fault_group <= {prb.page_group, {ht_slots{1'b0}}};
			end
		end
	end

	// A hit needs a valid matching slot and must never be turned into a fault
	a_no_fault_on_hit : assert property (
		@(posedge clk) disable iff (rst)
		(prb.xlat && prb.found) |-> (!prb.page_fault && !(&prb.empty))
	);

endmodule

`default_nettype wire

//--- verilog/ht_pkg.sv
`default_nettype none

package ht_pkg;

	// ==============================
	// Field widths
	// ==============================

	// Virtual and physical page number widths
	localparam int unsigned ht_vpn_w = 20;
	localparam int unsigned ht_ppn_w = 16;

	// Group index width, fixed by the layout of the fault word
	localparam int unsigned ht_group_w = 10;
	localparam int unsigned ht_groups  = 1 << ht_group_w;

	// Slots per group, which is also the width of an empty mask
	localparam int unsigned ht_slots = 8;

	// A stored slot holds the valid bit, then the VPN tag, then the PPN
	localparam int unsigned ht_entry_w = 1 + ht_vpn_w + ht_ppn_w;

	// Fault word holds a group index above the slot mask
	localparam int unsigned ht_fault_w = ht_group_w + ht_slots;

	// Bounce count and bounce limit share one width
	localparam int unsigned ht_bounce_w = 8;

	// Fault word after reset points at group zero with every slot marked empty
	localparam logic [ht_fault_w-1:0] ht_fault_rst = 18'h0ff;

	// ==============================
	// Hash
	// ==============================

	// Home group is the low ten bits folded onto the high ten bits
	function automatic logic [ht_group_w-1:0] ht_hash(input logic [ht_vpn_w-1:0] vpn);
		logic [ht_group_w-1:0] lo;
		logic [ht_group_w-1:0] hi;
		lo = vpn[ht_group_w-1:0];
		hi = vpn[ht_vpn_w-1 -: ht_group_w];
		return lo ^ hi;
	endfunction

endpackage

`default_nettype wire

//--- verilog/ht_probe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ht_probe_if;
	import ht_pkg::*;

	// Probe outcome, qualified by xlat for a single cycle
	logic                   xlat;
	logic                   found;
	logic [ht_slots-1:0]    empty;
	logic [ht_bounce_w-1:0] bounce;
	logic [ht_group_w-1:0]  current_group;
	logic [ht_group_w-1:0]  page_group;

	// Decision comes back in the same cycle, the fault word one edge later
	logic                   page_fault;
	logic [ht_fault_w-1:0]  fault_group;

	modport walker (
		output xlat, found, empty, bounce, current_group, page_group,
		input  page_fault, fault_group
	);

	modport detect (
		input  xlat, found, empty, bounce, current_group, page_group,
		output page_fault, fault_group
	);

endinterface

`default_nettype wire

//--- verilog/ht_walker.sv
`timescale 1ns/1ps
`default_nettype none

module ht_walker (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [ht_pkg::ht_bounce_w-1:0] max_bounce,
	input  logic                           req_valid,
	output logic                           req_ready,
	input  logic [ht_pkg::ht_vpn_w-1:0]    req_vpn,
	output logic                           resp_valid,
	input  logic                           resp_ready,
	output logic                           resp_found,
	output logic                           resp_fault,
	output logic [ht_pkg::ht_ppn_w-1:0]    resp_ppn,
	output logic [ht_pkg::ht_fault_w-1:0]  resp_fault_group,
	ht_group_if.walker                     grp,
	ht_probe_if.walker                     prb
);
	import ht_pkg::*;

	// ==============================
	// State
	// ==============================

	localparam logic [2:0] st_idle  = 3'd0;
	localparam logic [2:0] st_read  = 3'd1;
	localparam logic [2:0] st_cmp   = 3'd2;
	localparam logic [2:0] st_fault = 3'd3;
	localparam logic [2:0] st_resp  = 3'd4;

	logic [2:0]             state;
	logic [ht_bounce_w-1:0] bounce;

	// Latched request and the walk position
	logic [ht_vpn_w-1:0]    vpn_q;
	logic [ht_group_w-1:0]  home_group;
	logic [ht_group_w-1:0]  cur_group;

	// Compare results for the group on the read port
	logic                   found;
	logic [ht_ppn_w-1:0]    hit_ppn;
	logic [ht_slots-1:0]    empty;

	// ==============================
	// Tag compare
	// ==============================

	// All eight slots are checked at once
	// The lowest matching slot supplies the PPN
	always_comb begin : c_match
		logic [ht_entry_w-1:0] entry;
		logic                  hit;
		found   = 1'b0;
		hit_ppn = '0;
		empty   = '0;
		for (int s = ht_slots - 1; s >= 0; s--) begin
			entry    = grp.rd_slots[s*ht_entry_w +: ht_entry_w];
			hit      = entry[ht_entry_w-1] && (entry[ht_entry_w-2 -: ht_vpn_w] == vpn_q);
			empty[s] = !entry[ht_entry_w-1];
			if (hit) begin
				found   = 1'b1;
				hit_ppn = entry[ht_ppn_w-1:0];
			end
		end
	end

	// Read port follows the current group
	assign grp.rd_en    = (state == st_read);
	assign grp.rd_group = cur_group;

	// Probe outcome is only meaningful in the compare cycle
	assign prb.xlat          = (state == st_cmp);
	assign prb.found         = found;
	assign prb.empty         = empty;
	assign prb.bounce        = bounce;
	assign prb.current_group = cur_group;
	assign prb.page_group    = home_group;

	assign req_ready  = (state == st_idle);
	assign resp_valid = (state == st_resp);

	// ==============================
	// Control
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= st_idle;
			bounce <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (req_valid) begin
						state  <= st_read;
						bounce <= '0;
					end
				end
				st_read: begin
					state <= st_cmp;
				end
				st_cmp: begin
					if (found) begin
						state <= st_resp;
					end else if (prb.page_fault) begin
						state <= st_fault;
					end else begin
						// A full group without a match sends the walk to the neighbour
						state  <= st_read;
						bounce <= bounce + 1'b1;
					end
				end
				st_fault: begin
					state <= st_resp;
				end
				st_resp: begin
					// Hold everything until the consumer takes it
					if (resp_ready) begin
						state  <= st_idle;
						// Idle keeps a zero count while the limit may change
						bounce <= '0;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// ==============================
	// Request and response data
	// ==============================

	always_ff @(posedge clk) begin
		if (req_ready && req_valid) begin
			vpn_q      <= req_vpn;
			home_group <= ht_hash(req_vpn);
			cur_group  <= ht_hash(req_vpn);
		end else if ((state == st_cmp) && !found && !prb.page_fault) begin
			// Index width makes the last group wrap to group zero
			cur_group <= cur_group + 1'b1;
		end

		if (state == st_cmp) begin
			resp_found <= found;
			resp_fault <= !found;
			resp_ppn   <= found ? hit_ppn : '0;
			// A hit carries no fault group
			resp_fault_group <= '0;
		end else if (state == st_fault) begin
			// Detector registered the word on the compare edge
			resp_fault_group <= prb.fault_group;
		end
	end

	// The detector must stop the walk before the count passes the limit
	a_bounce_limit : assert property (
		@(posedge clk) disable iff (rst)
		bounce <= max_bounce
	);

endmodule

`default_nettype wire

//--- verilog/ht_xlat_top.sv
`timescale 1ns/1ps
`default_nettype none

module ht_xlat_top (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [ht_pkg::ht_bounce_w-1:0] max_bounce,

	input  logic                           req_valid,
	output logic                           req_ready,
	input  logic [ht_pkg::ht_vpn_w-1:0]    req_vpn,

	output logic                           resp_valid,
	input  logic                           resp_ready,
	output logic                           resp_found,
	output logic                           resp_fault,
	output logic [ht_pkg::ht_ppn_w-1:0]    resp_ppn,
	output logic [ht_pkg::ht_fault_w-1:0]  resp_fault_group,

	input  logic                           wr_en,
	input  logic [ht_pkg::ht_group_w-1:0]  wr_group,
	input  logic [2:0]                     wr_slot,
	input  logic [ht_pkg::ht_vpn_w-1:0]    wr_vpn,
	input  logic [ht_pkg::ht_ppn_w-1:0]    wr_ppn
);
	import ht_pkg::*;

	logic [ht_entry_w-1:0] wr_entry;

	// Anything written through the load port is a live translation
	assign wr_entry = {1'b1, wr_vpn, wr_ppn};

	ht_group_if u_grp_if ();
	ht_probe_if u_prb_if ();

	ht_walker u_walker (
		.clk              (clk),
		.rst              (rst),
		.max_bounce       (max_bounce),
		.req_valid        (req_valid),
		.req_ready        (req_ready),
		.req_vpn          (req_vpn),
		.resp_valid       (resp_valid),
		.resp_ready       (resp_ready),
		.resp_found       (resp_found),
		.resp_fault       (resp_fault),
		.resp_ppn         (resp_ppn),
		.resp_fault_group (resp_fault_group),
		.grp              (u_grp_if.walker),
		.prb              (u_prb_if.walker)
	);

	ht_group_ram u_group_ram (
		.clk      (clk),
		.wr_en    (wr_en),
		.wr_group (wr_group),
		.wr_slot  (wr_slot),
		.wr_entry (wr_entry),
		.grp      (u_grp_if.ram)
	);

	// Detector sees the same run-time bounce limit as the walker
	ht_page_fault u_page_fault (
		.clk        (clk),
		.rst        (rst),
		.max_bounce (max_bounce),
		.prb        (u_prb_if.detect)
	);

endmodule

`default_nettype wire
